/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_dual_issue_core -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* src.f */
+incdir+include
src/pipe_pkg.sv
src/isa_pkg.sv
src/wb_if.sv
src/issue_ctrl.sv
src/exec_lane.sv
src/arch_state.sv
src/dual_issue_core.sv
testbench/tb_dual_issue_core.sv

/* src/arch_state.sv */
`default_nettype none

module arch_state
    import pipe_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire reg_num_t rd_num0,
    input  wire reg_num_t rd_num1,
    input  wire reg_num_t rd_num2,
    input  wire reg_num_t rd_num3,
    output logic [DATA_W-1:0] rd_data0,
    output logic [DATA_W-1:0] rd_data1,
    output logic [DATA_W-1:0] rd_data2,
    output logic [DATA_W-1:0] rd_data3,

    wb_if.dst             wb0,
    wb_if.dst             wb1,

    output flags_t        flags
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              flag_upd;
    lane_t             flag_lane;

    assign rd_data0 = regs[rd_num0];
    assign rd_data1 = regs[rd_num1];
    assign rd_data2 = regs[rd_num2];
    assign rd_data3 = regs[rd_num3];

    // --------------------
    // Two write ports, lane 1 last so it wins a collision
    always_ff @(posedge clk) begin
        if (wb0.valid) begin
            regs[wb0.num] <= wb0.data;
        end
        if (wb1.valid) begin
            regs[wb1.num] <= wb1.data;
        end
    end

    // --------------------
    // Flags from the most recent setter
    assign flag_upd  = wb0.set_flags || wb1.set_flags;
    assign flag_lane = wb1.set_flags ? LANE1 : LANE0;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (flag_upd) begin
            flags <= (flag_lane == LANE1) ? wb1.flags : wb0.flags;
        end
    end

endmodule

`default_nettype wire

/* src/dual_issue_core.sv */
`default_nettype none

module dual_issue_core
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  wire logic         clk,
    input  wire logic         rst,

    input  wire logic         in_valid,
    output logic              in_ready,
    input  wire instr_t       in_instr0,
    input  wire instr_t       in_instr1,

    output logic              wb0_valid,
    output reg_num_t          wb0_num,
    output logic [DATA_W-1:0] wb0_data,
    output logic              wb1_valid,
    output reg_num_t          wb1_num,
    output logic [DATA_W-1:0] wb1_data,

    output flags_t            flags
);

    logic              issue0_valid;
    instr_t            issue0_instr;
    logic              issue1_valid;
    instr_t            issue1_instr;

    reg_num_t          rn_num0;
    reg_num_t          rm_num0;
    reg_num_t          rn_num1;
    reg_num_t          rm_num1;
    logic [DATA_W-1:0] rn_data0;
    logic [DATA_W-1:0] rm_data0;
    logic [DATA_W-1:0] rn_data1;
    logic [DATA_W-1:0] rm_data1;

    wb_if #(.DATA_W(DATA_W)) wb0 ();
    wb_if #(.DATA_W(DATA_W)) wb1 ();

    issue_ctrl issue_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr0    (in_instr0),
        .in_instr1    (in_instr1),
        .in_ready     (in_ready),
        .issue0_valid (issue0_valid),
        .issue0_instr (issue0_instr),
        .issue1_valid (issue1_valid),
        .issue1_instr (issue1_instr)
    );

    // --------------------
    // Lanes
    exec_lane #(.DATA_W(DATA_W), .LANE(LANE0)) lane0_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue0_valid),
        .issue_instr (issue0_instr),
        .rn_data     (rn_data0),
        .rm_data     (rm_data0),
        .rn_num      (rn_num0),
        .rm_num      (rm_num0),
        .own         (wb0),
        .other       (wb1)
    );

    exec_lane #(.DATA_W(DATA_W), .LANE(LANE1)) lane1_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue1_valid),
        .issue_instr (issue1_instr),
        .rn_data     (rn_data1),
        .rm_data     (rm_data1),
        .rn_num      (rn_num1),
        .rm_num      (rm_num1),
        .own         (wb1),
        .other       (wb0)
    );

    arch_state #(.DATA_W(DATA_W)) arch_state_i (
        .clk      (clk),
        .rst      (rst),
        .rd_num0  (rn_num0),
        .rd_num1  (rm_num0),
        .rd_num2  (rn_num1),
        .rd_num3  (rm_num1),
        .rd_data0 (rn_data0),
        .rd_data1 (rm_data0),
        .rd_data2 (rn_data1),
        .rd_data3 (rm_data1),
        .wb0      (wb0),
        .wb1      (wb1),
        .flags    (flags)
    );

    assign wb0_valid = wb0.valid;
    assign wb0_num   = wb0.num;
    assign wb0_data  = wb0.data;
    assign wb1_valid = wb1.valid;
    assign wb1_num   = wb1.num;
    assign wb1_data  = wb1.data;

endmodule

`default_nettype wire

/* src/exec_lane.sv */
`default_nettype none

module exec_lane
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int    DATA_W = 16,
    parameter lane_t LANE   = LANE0
) (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              issue_valid,
    input  wire instr_t            issue_instr,

    input  wire logic [DATA_W-1:0] rn_data,
    input  wire logic [DATA_W-1:0] rm_data,
    output reg_num_t               rn_num,
    output reg_num_t               rm_num,

    wb_if.src                      own,
    wb_if.dst                      other
);

    localparam int MSB = DATA_W - 1;

    logic              iss_valid;
    decoded_t          iss_d;

    logic              hi_valid;
    reg_num_t          hi_num;
    logic [DATA_W-1:0] hi_data;
    logic              lo_valid;
    reg_num_t          lo_num;
    logic [DATA_W-1:0] lo_data;

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic [DATA_W-1:0] result;
    logic              ovf;
    flags_t            alu_flags;

    // --------------------
    // Issue register
    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= issue_valid;
        end
        iss_d <= decode(issue_instr);
    end

    assign rn_num = iss_d.rn;
    assign rm_num = iss_d.rm;

    // --------------------
    // Forwarding, lane 1 writeback is the younger one
    assign hi_valid = (LANE == LANE1) ? own.valid : other.valid;
    assign hi_num   = (LANE == LANE1) ? own.num   : other.num;
    assign hi_data  = (LANE == LANE1) ? own.data  : other.data;
    assign lo_valid = (LANE == LANE1) ? other.valid : own.valid;
    assign lo_num   = (LANE == LANE1) ? other.num   : own.num;
    assign lo_data  = (LANE == LANE1) ? other.data  : own.data;

    assign op_a = (hi_valid && hi_num == iss_d.rn) ? hi_data :
                  (lo_valid && lo_num == iss_d.rn) ? lo_data : rn_data;
    assign op_b = (hi_valid && hi_num == iss_d.rm) ? hi_data :
                  (lo_valid && lo_num == iss_d.rm) ? lo_data : rm_data;

    // --------------------
    // ALU
    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        case (iss_d.op)
            OP_ADD: begin
                result = sum;
                ovf    = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);
            end
            OP_SUB, OP_CMP: begin
                result = diff;
                ovf    = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);
            end
            OP_AND:  result = op_a & op_b;
            OP_ORR:  result = op_a | op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_MOVI: result = DATA_W'(iss_d.imm);   // Zero-extended
            default: result = '0;
        endcase
    end

    assign alu_flags.n = result[MSB];
    assign alu_flags.z = (result == '0);
    assign alu_flags.v = ovf;

    // --------------------
    // Writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            own.valid     <= 1'b0;
            own.set_flags <= 1'b0;
        end else begin
            own.valid     <= iss_valid && iss_d.wr_rd;
            own.set_flags <= iss_valid && iss_d.set_flags;
        end
        own.num   <= iss_d.rd;
        own.data  <= result;
        own.flags <= alu_flags;
    end

endmodule

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_ORR  = 4'h4,
        OP_XOR  = 4'h5,
        OP_MOVI = 4'h6,
        OP_CMP  = 4'h7
    } opcode_t;

    typedef logic [15:0] instr_t;
    typedef logic [7:0]  imm_t;
    typedef logic [1:0]  src_mask_t;    // {rn, rm}

    typedef struct packed {
        opcode_t            op;
        pipe_pkg::reg_num_t rd;
        pipe_pkg::reg_num_t rn;
        pipe_pkg::reg_num_t rm;
        imm_t               imm;
        logic               wr_rd;
        logic               set_flags;
        src_mask_t          reads;
    } decoded_t;

    function automatic logic writes_rd(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_XOR, OP_MOVI};
    endfunction

    // CMP updates flags only
    function automatic logic sets_flags(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_CMP};
    endfunction

    function automatic src_mask_t reads_regs(opcode_t op);
        return (op == OP_NOP || op == OP_MOVI) ? 2'b00 : 2'b11;
    endfunction

    function automatic decoded_t decode(instr_t instr);
        decoded_t d;
        d.op        = opcode_t'(instr[15:12]);
        d.rd        = instr[11:9];
        d.rn        = instr[8:6];
        d.rm        = instr[5:3];
        d.imm       = instr[7:0];   // Overlaps rn/rm, MOVI only
        d.wr_rd     = writes_rd(d.op);
        d.set_flags = sets_flags(d.op);
        d.reads     = reads_regs(d.op);
        return d;
    endfunction

endpackage

`default_nettype wire

/* src/issue_ctrl.sv */
`default_nettype none

module issue_ctrl
    import isa_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,

    input  wire logic   in_valid,
    input  wire instr_t in_instr0,
    input  wire instr_t in_instr1,
    output logic        in_ready,

    output logic        issue0_valid,
    output instr_t      issue0_instr,
    output logic        issue1_valid,
    output instr_t      issue1_instr
);

    decoded_t d0;
    decoded_t d1;
    logic     accept;
    logic     dep;
    logic     pending;
    instr_t   pend_instr;

    assign d0 = decode(in_instr0);
    assign d1 = decode(in_instr1);

    // instr1 needs instr0's result
    assign dep = d0.wr_rd &&
                 ((d1.reads[1] && d1.rn == d0.rd) || (d1.reads[0] && d1.rm == d0.rd));

    assign in_ready = !pending;
    assign accept   = in_valid && in_ready;

    // --------------------
    // Lane drive
    assign issue0_valid = accept && d0.op != OP_NOP;
    assign issue0_instr = in_instr0;

    assign issue1_valid = pending ? 1'b1 : (accept && !dep && d1.op != OP_NOP);
    assign issue1_instr = pending ? pend_instr : in_instr1;

    // --------------------
    // Split pair, second half next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (pending) begin
            pending <= 1'b0;
        end else if (accept && dep) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && dep) begin
            pend_instr <= in_instr1;
        end
    end

endmodule

`default_nettype wire

/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    typedef logic [2:0] reg_num_t;

    localparam int NUM_REGS = 2 ** $bits(reg_num_t);

    typedef struct packed {
        logic n;
        logic z;
        logic v;
    } flags_t;

    // Lane 1 carries the later instruction of a pair
    typedef logic lane_t;

    localparam lane_t LANE0 = 1'b0;
    localparam lane_t LANE1 = 1'b1;

endpackage

`default_nettype wire

/* src/wb_if.sv */
`default_nettype none

interface wb_if
    import pipe_pkg::*;
#(
    parameter int DATA_W = 16
) ();

    logic              valid;       // Register write
    reg_num_t          num;
    logic [DATA_W-1:0] data;
    logic              set_flags;
    flags_t            flags;

    modport src (
        output valid, num, data, set_flags, flags
    );

    modport dst (
        input valid, num, data, set_flags, flags
    );

endinterface

`default_nettype wire

/* include/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// One row per instruction pair
typedef struct packed {
    instr_t i0;
    instr_t i1;
    logic   hold;       // Random idle cycles before the pair
    logic   chk_flags;  // Drain and compare flags after this row
} pair_t;

localparam int PROG_LEN = 12;

// Last flag setter is the overflowing CMP in row 10
localparam flags_t EXP_FINAL_FLAGS = '{n: 1'b1, z: 1'b0, v: 1'b1};

pair_t prog [PROG_LEN];

function automatic instr_t enc_rrr(opcode_t op, reg_num_t rd, reg_num_t rn, reg_num_t rm);
    return {op, rd, rn, rm, 3'b000};
endfunction

function automatic instr_t enc_movi(reg_num_t rd, logic [7:0] imm);
    return {OP_MOVI, rd, 1'b0, imm};
endfunction

task automatic fill_program();
    prog[0]  = '{enc_movi(3'd0, 8'h00), enc_movi(3'd1, 8'h05), 1'b0, 1'b0};
    prog[1]  = '{enc_movi(3'd2, 8'h7f), enc_movi(3'd3, 8'h80), 1'b1, 1'b0};
    // Operands from the row before and flags from both lanes
    prog[2]  = '{enc_rrr(OP_ADD, 3'd4, 3'd1, 3'd2), enc_rrr(OP_SUB, 3'd5, 3'd1, 3'd3),
                 1'b0, 1'b1};
    // Dependent pairs that keep doubling r6
    prog[3]  = '{enc_rrr(OP_ADD, 3'd6, 3'd4, 3'd4), enc_rrr(OP_ADD, 3'd6, 3'd6, 3'd6),
                 1'b0, 1'b0};
    prog[4]  = '{enc_rrr(OP_ADD, 3'd6, 3'd6, 3'd6), enc_rrr(OP_ADD, 3'd6, 3'd6, 3'd6),
                 1'b0, 1'b0};
    prog[5]  = '{enc_rrr(OP_ADD, 3'd6, 3'd6, 3'd6), enc_rrr(OP_ADD, 3'd6, 3'd6, 3'd6),
                 1'b1, 1'b0};
    prog[6]  = '{enc_rrr(OP_ADD, 3'd6, 3'd6, 3'd6), enc_rrr(OP_XOR, 3'd7, 3'd1, 3'd1),
                 1'b0, 1'b1};
    // Same destination in both lanes
    prog[7]  = '{enc_movi(3'd2, 8'h11), enc_movi(3'd2, 8'h22), 1'b1, 1'b0};
    prog[8]  = '{enc_rrr(OP_ADD, 3'd3, 3'd2, 3'd0), enc_rrr(OP_AND, 3'd4, 3'd6, 3'd6),
                 1'b0, 1'b0};
    prog[9]  = '{enc_rrr(OP_ADD, 3'd5, 3'd6, 3'd6), enc_rrr(OP_ORR, 3'd7, 3'd1, 3'd2),
                 1'b0, 1'b1};
    prog[10] = '{enc_rrr(OP_SUB, 3'd1, 3'd1, 3'd1), enc_rrr(OP_CMP, 3'd0, 3'd6, 3'd5),
                 1'b0, 1'b1};
    prog[11] = '{enc_movi(3'd7, 8'h33), enc_rrr(OP_NOP, 3'd0, 3'd0, 3'd0), 1'b1, 1'b1};
endtask

`endif

/* testbench/tb_dual_issue_core.sv */
`default_nettype none

module tb_dual_issue_core
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int DATA_W = 16;
    localparam int MSB    = DATA_W - 1;

    typedef struct packed {
        reg_num_t          num;
        logic [DATA_W-1:0] data;
    } wr_t;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    instr_t            in_instr0;
    instr_t            in_instr1;
    logic              wb0_valid;
    reg_num_t          wb0_num;
    logic [DATA_W-1:0] wb0_data;
    logic              wb1_valid;
    reg_num_t          wb1_num;
    logic [DATA_W-1:0] wb1_data;
    flags_t            flags;

    logic [DATA_W-1:0] model_regs [NUM_REGS];
    flags_t            model_flags;
    wr_t               exp_q [$];
    int                checks;
    int                errors;
    logic              ready_due;
    logic              exp_ready;

    `include "tb_program.svh"

    dual_issue_core #(.DATA_W(DATA_W)) dual_issue_core_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr0 (in_instr0),
        .in_instr1 (in_instr1),
        .wb0_valid (wb0_valid),
        .wb0_num   (wb0_num),
        .wb0_data  (wb0_data),
        .wb1_valid (wb1_valid),
        .wb1_num   (wb1_num),
        .wb1_data  (wb1_data),
        .flags     (flags)
    );

    always #10 clk = !clk;

    // --------------------
    // Compare tasks
    task automatic compare_reg(string name, reg_num_t got_num, logic [DATA_W-1:0] got_data,
                               reg_num_t exp_num, logic [DATA_W-1:0] exp_data);
        checks++;
        if (got_num !== exp_num || got_data !== exp_data) begin
            errors++;
            $display("[FAIL] %0t %s: got r%0d=%h, expected r%0d=%h",
                     $time, name, got_num, got_data, exp_num, exp_data);
        end
    endtask

    task automatic compare_flags(string name, flags_t got, flags_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got nzv=%b, expected nzv=%b", $time, name, got, exp);
        end
    endtask

    task automatic compare_ready(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // --------------------
    // Reference model in program order
    task automatic model_exec(instr_t instr);
        decoded_t          d;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] res;
        logic [DATA_W:0]   wide;
        logic              v;
        d    = decode(instr);
        a    = model_regs[d.rn];
        b    = model_regs[d.rm];
        res  = '0;
        wide = '0;
        v    = 1'b0;
        case (d.op)
            OP_ADD: begin
                wide = {a[MSB], a} + {b[MSB], b};  // One guard bit
                res  = wide[MSB:0];
                v    = wide[DATA_W] != wide[MSB];
            end
            OP_SUB, OP_CMP: begin
                wide = {a[MSB], a} - {b[MSB], b};
                res  = wide[MSB:0];
                v    = wide[DATA_W] != wide[MSB];
            end
            OP_AND:  res = a & b;
            OP_ORR:  res = a | b;
            OP_XOR:  res = a ^ b;
            OP_MOVI: res = {{(DATA_W-8){1'b0}}, d.imm};
            default: res = '0;
        endcase
        if (d.wr_rd) begin
            model_regs[d.rd] = res;
            exp_q.push_back('{num: d.rd, data: res});
        end
        if (d.set_flags) begin
            model_flags = '{n: res[MSB], z: (res == '0), v: v};
        end
    endtask

    // Second instruction uses a register that the first one writes
    function automatic logic reads_dest(instr_t first, instr_t second);
        decoded_t d0;
        decoded_t d1;
        logic     uses_regs;
        d0 = decode(first);
        d1 = decode(second);
        uses_regs = !(d1.op inside {OP_NOP, OP_MOVI});
        return d0.wr_rd && uses_regs && (d1.rn == d0.rd || d1.rm == d0.rd);
    endfunction

    // Holds the pair until accepted
    task automatic drive_pair(pair_t p);
        logic rdy;
        in_valid  <= 1'b1;
        in_instr0 <= p.i0;
        in_instr1 <= p.i1;
        do begin
            @(negedge clk);
            rdy = in_ready;
            @(posedge clk);
        end while (!rdy);
        model_exec(p.i0);
        model_exec(p.i1);
    endtask

    // --------------------
    // Writeback monitor
    always @(negedge clk) begin
        if (!rst && wb0_valid === 1'b1) begin   // Lane 0 first
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0t: lane 0 wrote back with no write expected", $time);
            end else begin
                compare_reg("wb0", wb0_num, wb0_data, exp_q[0].num, exp_q[0].data);
                void'(exp_q.pop_front());
            end
        end
        if (!rst && wb1_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0t: lane 1 wrote back with no write expected", $time);
            end else begin
                compare_reg("wb1", wb1_num, wb1_data, exp_q[0].num, exp_q[0].data);
                void'(exp_q.pop_front());
            end
        end
    end

    // in_ready in the cycle after each accepted pair
    always @(negedge clk) begin
        if (rst) begin
            ready_due = 1'b0;
        end else begin
            if (ready_due) begin
                compare_ready("in_ready", in_ready, exp_ready);
            end
            ready_due = in_valid && in_ready;
            exp_ready = !reads_dest(in_instr0, in_instr1);
        end
    end

    initial begin
        repeat (PROG_LEN * 10 + 100) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", PROG_LEN * 10 + 100);
        $display("RESULT: FAIL");
        $finish;
    end

    // --------------------
    // Table driver
    initial begin
        int idle;
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_instr0   = '0;
        in_instr1   = '0;
        model_flags = '0;
        checks      = 0;
        errors      = 0;
        void'($urandom(27569));
        fill_program();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < PROG_LEN; r++) begin
            if (prog[r].hold) begin
                in_valid <= 1'b0;
                idle = $urandom % 4;
                repeat (idle) @(posedge clk);
            end
            drive_pair(prog[r]);
            if (prog[r].chk_flags) begin
                in_valid <= 1'b0;
                repeat (3) @(posedge clk);
                @(negedge clk);
                compare_flags("flags", flags, model_flags);
                @(posedge clk);
            end
            $display("row %0d done, errors so far %0d", r, errors);
        end
        in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected writebacks never appeared", exp_q.size());
        end
        compare_flags("flags", flags, model_flags);
        compare_flags("flags", flags, EXP_FINAL_FLAGS);
        $display("rows %0d, checks %0d, errors %0d", PROG_LEN, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
